/* Makefile */
# Verilator build and run of the mini_rv_core testbench

VERILATOR ?= verilator
TOP       ?= tb_mini_rv_core
FILELIST  ?= mini_rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data and address width
`define XLEN 32

// Architectural registers, x0 included
`define NREG 32
`define REG_ADDR_W 5

// Byte distance between sequential instructions
`define INSTR_STEP 4

`endif

/* common/core_pkg.sv */
`include "core_macros.svh"

package core_pkg;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLL    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_PASS_B = 4'd8
  } alu_op_e;

  //////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////

  // Fetch buffer entry, IF to ID
  typedef struct packed {
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
  } fetch_t;

  // Decode/execute register contents
  typedef struct packed {
    logic                   valid;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       operand_a;
    logic [`XLEN-1:0]       operand_b;
    logic                   we;
    logic [`REG_ADDR_W-1:0] waddr;
    logic                   is_store;
    logic [`XLEN-1:0]       store_data;
  } id_ex_t;

  // Store handed from execute to the LSU
  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } store_req_t;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // funct3 of the arithmetic and logic group
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // funct7, the alternate form picks SUB and SRA
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000
  } funct7_e;

  // Word store width field
  localparam logic [2:0] F3_SW = 3'b010;

endpackage

/* dv/mini_rv_core_chk.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module mini_rv_core_chk (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             instr_req_o,
  input logic             instr_gnt_i,
  input logic [`XLEN-1:0] instr_addr_o,
  input logic             data_req_o,
  input logic             data_gnt_i,
  input logic [`XLEN-1:0] data_addr_o,
  input logic [`XLEN-1:0] data_wdata_o
);

  // Fetch request held with its address until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("fetch request dropped or moved before its grant");

  // Store request, address and data held until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o) && $stable(data_wdata_o))
    else $error("store request dropped or changed before its grant");

  // Both ports quiet in reset
  assert property (@(posedge clk_i) !rst_ni |-> !instr_req_o && !data_req_o)
    else $error("request raised while in reset");

endmodule

bind mini_rv_core mini_rv_core_chk u_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .instr_req_o  (instr_req_o),
  .instr_gnt_i  (instr_gnt_i),
  .instr_addr_o (instr_addr_o),
  .data_req_o   (data_req_o),
  .data_gnt_i   (data_gnt_i),
  .data_addr_o  (data_addr_o),
  .data_wdata_o (data_wdata_o)
);

/* dv/tb_mini_rv_core.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module tb_mini_rv_core
  import isa_pkg::*;
;

  // DUT inputs start idle
  logic             clk_i;
  logic             rst_ni         = 1'b0;
  logic [`XLEN-1:0] boot_addr_i    = 32'h0000_0100;
  logic             instr_gnt_i    = 1'b0;
  logic             instr_rvalid_i = 1'b0;
  logic [`XLEN-1:0] instr_rdata_i  = '0;
  logic             data_gnt_i     = 1'b0;
  // DUT outputs
  logic             instr_req_o;
  logic [`XLEN-1:0] instr_addr_o;
  logic             data_req_o;
  logic [`XLEN-1:0] data_addr_o;
  logic [`XLEN-1:0] data_wdata_o;

  // Program image and expected stores
  logic [`XLEN-1:0] prog_q[$];
  string            tag_q[$];
  logic [`XLEN-1:0] exp_addr_q[$];
  logic [`XLEN-1:0] exp_data_q[$];
  string            exp_tag_q[$];
  int               n_stores;
  int               fetch_cnt = 0;
  int               store_cnt = 0;
  logic             run_done  = 1'b0;
  integer           seed      = 32'h0d01_14cb;

  // Memory model state
  int               igw     = 0;
  int               dgw     = 0;
  int               rd_wait = 0;
  logic             rd_pend = 1'b0;
  logic [`XLEN-1:0] rd_addr = '0;

  mini_rv_core UUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Encoders and program
  //////////////////////////////////////////////////

  function automatic logic [31:0] enc_i(logic [6:0] opc, logic [2:0] f3, int rd, int rs1,
                                        int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
                                        int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
  endfunction

  // rs1 is the base and rs2 the data
  function automatic logic [31:0] enc_s(logic [2:0] f3, int rs1, int rs2, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_u(logic [6:0] opc, int rd, int imm20);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  task automatic emit(string tag, logic [31:0] ins);
    prog_q.push_back(ins);
    tag_q.push_back(tag);
  endtask

  task automatic build_program();
    // Base x10 = 0x2000 and x1 = 0xdeadb7ef
    emit("imm_lui", enc_u(OPC_LUI, 10, 'h00002));
    emit("imm_lui", enc_u(OPC_LUI, 1, 'hdeadb));
    emit("imm_lui", enc_i(OPC_OP_IMM, 3'b000, 1, 1, 'h7ef));
    emit("imm_lui", enc_i(OPC_OP_IMM, 3'b000, 2, 0, -5));
    emit("imm_lui", enc_i(OPC_OP_IMM, 3'b111, 3, 1, 'h0f0));
    emit("imm_lui", enc_i(OPC_OP_IMM, 3'b110, 4, 3, -2048));
    emit("imm_lui", enc_i(OPC_OP_IMM, 3'b100, 5, 1, -1));
    for (int r = 1; r <= 5; r++) emit("imm_lui", enc_s(3'b010, 10, r, (r - 1) * 4));
    // Each op reads the one just before it
    emit("rr_bypass", enc_r(7'h00, 3'b000, 6, 1, 2));
    emit("rr_bypass", enc_r(7'h20, 3'b000, 7, 6, 1));
    emit("rr_bypass", enc_r(7'h00, 3'b111, 8, 7, 6));
    emit("rr_bypass", enc_r(7'h00, 3'b110, 9, 8, 5));
    emit("rr_bypass", enc_r(7'h00, 3'b100, 11, 9, 7));
    emit("rr_bypass", enc_s(3'b010, 10, 11, 20));
    emit("rr_bypass", enc_r(7'h00, 3'b000, 12, 11, 11));
    emit("rr_bypass", enc_s(3'b010, 10, 12, -4));
    for (int r = 6; r <= 9; r++) emit("rr_bypass", enc_s(3'b010, 10, r, r * 4));
    // Store base straight from execute
    emit("rr_bypass", enc_i(OPC_OP_IMM, 3'b000, 10, 10, 64));
    emit("rr_bypass", enc_s(3'b010, 10, 1, 0));
    // Shift amount register holds 0xffffffe5 with low bits 5
    emit("shifts", enc_i(OPC_OP_IMM, 3'b000, 13, 0, -27));
    emit("shifts", enc_r(7'h00, 3'b001, 14, 1, 13));
    emit("shifts", enc_r(7'h00, 3'b101, 15, 1, 13));
    emit("shifts", enc_r(7'h20, 3'b101, 16, 1, 13));
    emit("shifts", enc_i(OPC_OP_IMM, 3'b001, 17, 1, 31));
    emit("shifts", enc_i(OPC_OP_IMM, 3'b101, 18, 2, 'h401));
    emit("shifts", enc_i(OPC_OP_IMM, 3'b101, 19, 1, 28));
    emit("shifts", enc_r(7'h20, 3'b101, 20, 1, 0));
    for (int r = 14; r <= 20; r++) emit("shifts", enc_s(3'b010, 10, r, (r - 13) * 4));
    // Writes to x0 followed by ignored encodings aimed at x1
    emit("x0_illegal", enc_i(OPC_OP_IMM, 3'b000, 0, 0, 55));
    emit("x0_illegal", enc_r(7'h00, 3'b000, 0, 1, 1));
    emit("x0_illegal", enc_s(3'b010, 10, 0, 32));
    emit("x0_illegal", enc_i(7'b0000011, 3'b010, 1, 10, 0));
    emit("x0_illegal", enc_i(7'b1100011, 3'b000, 1, 1, 0));
    emit("x0_illegal", enc_u(7'b1101111, 1, 'h00010));
    emit("x0_illegal", enc_i(OPC_OP_IMM, 3'b010, 1, 0, 1));
    emit("x0_illegal", enc_i(OPC_OP_IMM, 3'b001, 1, 1, 'h401));
    emit("x0_illegal", enc_r(7'h01, 3'b000, 1, 1, 1));
    emit("x0_illegal", enc_r(7'h20, 3'b100, 1, 1, 1));
    emit("x0_illegal", enc_s(3'b000, 10, 1, 36));
    emit("x0_illegal", enc_s(3'b010, 10, 1, 36));
    emit("x0_illegal", enc_i(OPC_OP_IMM, 3'b000, 21, 1, 1));
    emit("x0_illegal", enc_s(3'b010, 10, 21, 40));
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // RV32I integer result for funct3 with alt taken from instruction bit 30
  function automatic logic [31:0] int_op(logic [2:0] f3, logic alt, logic [31:0] a,
                                         logic [31:0] b);
    logic [31:0] r;
    r = '0;
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << b[4:0];
      3'b100: r = a ^ b;
      3'b110: r = a | b;
      3'b111: r = a & b;
      3'b101: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  // Runs the program in order and collects the stores it makes
  function automatic void run_reference();
    logic [31:0] regs [32];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        wr;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    for (int k = 0; k < prog_q.size(); k++) begin
      ins = prog_q[k];
      f3  = ins[14:12];
      f7  = ins[31:25];
      a   = regs[ins[19:15]];
      b   = regs[ins[24:20]];
      wr  = 1'b0;
      res = '0;
      case (ins[6:0])
        OPC_LUI: begin
          wr  = 1'b1;
          res = {ins[31:12], 12'h000};
        end
        OPC_OP_IMM: begin
          wr = (f3 inside {3'b000, 3'b100, 3'b110, 3'b111}) || (f3 == 3'b001 && f7 == 7'h00)
               || (f3 == 3'b101 && (f7 == 7'h00 || f7 == 7'h20));
          res = int_op(f3, f3 == 3'b101 && f7 == 7'h20, a, {{20{ins[31]}}, ins[31:20]});
        end
        OPC_OP: begin
          wr = (f7 == 7'h00 && f3 != 3'b010 && f3 != 3'b011)
               || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
          res = int_op(f3, f7 == 7'h20, a, b);
        end
        OPC_STORE: begin
          if (f3 == 3'b010) begin
            exp_addr_q.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
            exp_data_q.push_back(b);
            exp_tag_q.push_back(tag_q[k]);
          end
        end
        default: ;
      endcase
      if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
    end
  endfunction

  //////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Custom-0 opcode past the program acts as a no-op on this core
  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - boot_addr_i) >> 2;
    if (addr >= boot_addr_i && idx < 32'(prog_q.size())) fetch_word = prog_q[idx];
    else fetch_word = {addr[31:7] ^ addr[24:0], 7'b0001011};
  endfunction

  // Grants may be raised ahead of the request
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      data_gnt_i     <= 1'b0;
    end else begin
      if (instr_req_o && instr_gnt_i) begin
        rd_addr = instr_addr_o;
        rd_pend = 1'b1;
        rd_wait = rand_below(3);
        igw     = rand_below(4);
      end else if (instr_req_o && igw > 0) begin
        igw--;
      end
      instr_gnt_i <= (igw == 0);
      // Read data 1 to 3 cycles after the grant
      if (rd_pend && rd_wait == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= fetch_word(rd_addr);
        rd_pend = 1'b0;
      end else begin
        instr_rvalid_i <= 1'b0;
        if (rd_pend) rd_wait--;
      end
      if (data_req_o && data_gnt_i) dgw = rand_below(5);
      else if (data_req_o && dgw > 0) dgw--;
      data_gnt_i <= (dgw == 0);
    end
  end

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    run_done = 1'b1;
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  // Handshakes seen with pre-edge values
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (instr_req_o && instr_gnt_i) begin
        check_value("fetch_addr", boot_addr_i + `XLEN'(fetch_cnt * `INSTR_STEP), instr_addr_o);
        fetch_cnt++;
      end
      if (data_req_o && data_gnt_i) begin
        if (store_cnt >= n_stores) begin
          abort_run($sformatf("Unexpected store to %08h after the last expected one",
                              data_addr_o));
        end else begin
          check_value($sformatf("%s store %0d addr", exp_tag_q[store_cnt], store_cnt),
                      exp_addr_q[store_cnt], data_addr_o);
          check_value($sformatf("%s store %0d data", exp_tag_q[store_cnt], store_cnt),
                      exp_data_q[store_cnt], data_wdata_o);
          store_cnt++;
        end
      end
    end
  end

  initial begin
    build_program();
    run_reference();
    n_stores = exp_addr_q.size();
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (store_cnt < n_stores) @(posedge clk_i);
    // Quiet window in which no stray store may appear
    repeat (40) @(posedge clk_i);
    run_done = 1'b1;
    $display("Result: PASSED");
    $finish;
  end

  // Watchdog allows 16 cycles per instruction plus the quiet window
  initial begin
    int limit;
    repeat (8) @(posedge clk_i);
    limit = prog_q.size() * 16 + 40;
    repeat (limit) @(posedge clk_i);
    abort_run($sformatf("Timeout: run did not finish within %0d cycles", limit));
  end

  // Run cut short elsewhere such as by an assertion
  final begin
    if (!run_done) begin
      $display("Run ended before all checks completed");
      $display("Result: FAILED");
    end
  end

endmodule

/* hw/ex_stage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module ex_stage
  import core_pkg::*;
(
  input  id_ex_t                 id_ex_i,
  input  logic                   lsu_busy_i,
  output logic                   ex_ready_o,
  output logic                   rf_we_o,
  output logic [`REG_ADDR_W-1:0] rf_waddr_o,
  output logic [`XLEN-1:0]       rf_wdata_o,
  output store_req_t             store_o
);

  logic [`XLEN-1:0] alu_result;
  logic [4:0]       shamt;
  logic             store_stall;

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  // Low five bits only
  assign shamt = id_ex_i.operand_b[4:0];

  always_comb begin
    case (id_ex_i.alu_op)
      ALU_ADD:    alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
      ALU_SUB:    alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      ALU_AND:    alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      ALU_OR:     alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      ALU_XOR:    alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      ALU_SLL:    alu_result = id_ex_i.operand_a << shamt;
      ALU_SRL:    alu_result = id_ex_i.operand_a >> shamt;
      ALU_SRA:    alu_result = $signed(id_ex_i.operand_a) >>> shamt;
      ALU_PASS_B: alu_result = id_ex_i.operand_b;
      default:    alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Write-back and store hand-off
  //////////////////////////////////////////////////

  // A store waits here while the LSU holds the previous one
  assign store_stall = id_ex_i.valid & id_ex_i.is_store & lsu_busy_i;
  assign ex_ready_o  = ~store_stall;

  // Also the bypass source for decode
  assign rf_we_o    = id_ex_i.valid & id_ex_i.we;
  assign rf_waddr_o = id_ex_i.waddr;
  assign rf_wdata_o = alu_result;

  // Store address is the adder sum of rs1 and imm
  assign store_o.valid = id_ex_i.valid & id_ex_i.is_store & ~store_stall;
  assign store_o.addr  = alu_result;
  assign store_o.wdata = id_ex_i.store_data;

endmodule

/* hw/id_stage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module id_stage
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_t                 fetch_i,
  input  logic                   fetch_valid_i,
  output logic                   fetch_ready_o,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`XLEN-1:0]       rs1_data_i,
  input  logic [`XLEN-1:0]       rs2_data_i,
  input  logic                   fwd_we_i,
  input  logic [`REG_ADDR_W-1:0] fwd_addr_i,
  input  logic [`XLEN-1:0]       fwd_data_i,
  input  logic                   ex_ready_i,
  output id_ex_t                 id_ex_o
);

  logic [`XLEN-1:0]       instr;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  funct3_e                f3;
  funct7_e                f7;
  logic [`XLEN-1:0]       imm_i;
  logic [`XLEN-1:0]       imm_s;
  logic [`XLEN-1:0]       imm_u;
  logic [`XLEN-1:0]       rs1_val;
  logic [`XLEN-1:0]       rs2_val;
  logic [`XLEN-1:0]       op_b;
  alu_op_e                alu_op;
  logic                   dec_we;
  logic                   dec_store;
  id_ex_t                 id_ex_d;
  id_ex_t                 id_ex_q;

  // funct3 to ALU op, alt picks SUB or SRA
  function automatic alu_op_e alu_from_funct(funct3_e fn3, logic alt);
    alu_op_e op;
    case (fn3)
      F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  //////////////////////////////////////////////////
  // Fields and immediates
  //////////////////////////////////////////////////

  assign instr      = fetch_i.instr;
  assign rs1        = instr[19:15];
  assign rs2        = instr[24:20];
  assign f3         = funct3_e'(instr[14:12]);
  assign f7         = funct7_e'(instr[31:25]);
  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  // Bypass from execute, x0 never forwarded
  assign rs1_val = (fwd_we_i && fwd_addr_i == rs1 && rs1 != '0) ? fwd_data_i : rs1_data_i;
  assign rs2_val = (fwd_we_i && fwd_addr_i == rs2 && rs2 != '0) ? fwd_data_i : rs2_data_i;

  //////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////

  // Anything not matched leaves we and store low, a plain no-op
  always_comb begin
    alu_op    = ALU_ADD;
    op_b      = imm_i;
    dec_we    = 1'b0;
    dec_store = 1'b0;
    case (opcode_e'(instr[6:0]))
      OPC_OP_IMM: begin
        case (f3)
          F3_ADD_SUB, F3_XOR, F3_OR, F3_AND: dec_we = 1'b1;
          F3_SLL:     dec_we = (f7 == F7_BASE);
          F3_SRL_SRA: dec_we = (f7 == F7_BASE) || (f7 == F7_ALT);
          default:    dec_we = 1'b0;
        endcase
        // ADDI ignores bit 30, it is immediate
        alu_op = alu_from_funct(f3, (f3 == F3_SRL_SRA) && (f7 == F7_ALT));
      end
      OPC_OP: begin
        op_b = rs2_val;
        case (f3)
          F3_ADD_SUB, F3_SRL_SRA:        dec_we = (f7 == F7_BASE) || (f7 == F7_ALT);
          F3_SLL, F3_XOR, F3_OR, F3_AND: dec_we = (f7 == F7_BASE);
          default:                       dec_we = 1'b0;
        endcase
        alu_op = alu_from_funct(f3, f7 == F7_ALT);
      end
      OPC_LUI: begin
        op_b   = imm_u;
        alu_op = ALU_PASS_B;
        dec_we = 1'b1;
      end
      OPC_STORE: begin
        // Address is rs1 plus the S immediate
        op_b      = imm_s;
        dec_store = (instr[14:12] == F3_SW);
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Decode/execute register
  //////////////////////////////////////////////////

  always_comb begin
    id_ex_d.valid      = fetch_valid_i;
    id_ex_d.alu_op     = alu_op;
    id_ex_d.operand_a  = rs1_val;
    id_ex_d.operand_b  = op_b;
    id_ex_d.we         = fetch_valid_i & dec_we;
    id_ex_d.waddr      = instr[11:7];
    id_ex_d.is_store   = fetch_valid_i & dec_store;
    id_ex_d.store_data = rs2_val;
  end

  // Bubble loaded when the buffer is empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_ex_q <= '0;
    end else if (ex_ready_i) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign fetch_ready_o = ex_ready_i;
  assign id_ex_o       = id_ex_q;

endmodule

/* hw/if_stage.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module if_stage
  import core_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [`XLEN-1:0] boot_addr_i,
  output logic             instr_req_o,
  input  logic             instr_gnt_i,
  output logic [`XLEN-1:0] instr_addr_o,
  input  logic             instr_rvalid_i,
  input  logic [`XLEN-1:0] instr_rdata_i,
  output fetch_t           fetch_o,
  output logic             fetch_valid_o,
  input  logic             fetch_ready_i
);

  logic             started_q;
  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] pc_pend_q;
  logic             outstanding_q;
  logic             buf_valid_q;
  fetch_t           buf_q;
  logic             buf_free;
  logic             req_fire;

  //////////////////////////////////////////////////
  // Request sequencing
  //////////////////////////////////////////////////

  // Buffer empty, or drained by decode this cycle
  assign buf_free     = ~buf_valid_q | fetch_ready_i;
  // One request at a time
  assign instr_req_o  = started_q & ~outstanding_q & buf_free;
  assign req_fire     = instr_req_o & instr_gnt_i;
  assign instr_addr_o = pc_q;

  // PC loads the boot address in the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q     <= 1'b0;
      pc_q          <= '0;
      outstanding_q <= 1'b0;
    end else begin
      if (!started_q) begin
        started_q <= 1'b1;
        pc_q      <= boot_addr_i;
      end else if (req_fire) begin
        pc_q <= pc_q + `XLEN'(`INSTR_STEP);
      end
      // Granted until its read data returns
      if (req_fire) begin
        outstanding_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // Address of the granted request
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      pc_pend_q <= pc_q;
    end
  end

  //////////////////////////////////////////////////
  // Fetch buffer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (instr_rvalid_i) begin
      buf_valid_q <= 1'b1;
    end else if (fetch_ready_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_rvalid_i) begin
      buf_q.instr <= instr_rdata_i;
      buf_q.pc    <= pc_pend_q;
    end
  end

  assign fetch_o       = buf_q;
  assign fetch_valid_o = buf_valid_q;

endmodule

/* hw/lsu.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module lsu
  import core_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  store_req_t       store_i,
  output logic             busy_o,
  output logic             data_req_o,
  input  logic             data_gnt_i,
  output logic [`XLEN-1:0] data_addr_o,
  output logic [`XLEN-1:0] data_wdata_o
);

  logic             req_q;
  logic [`XLEN-1:0] addr_q;
  logic [`XLEN-1:0] wdata_q;

  //////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////

  // New store in the grant cycle keeps req high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
    end else if (store_i.valid) begin
      req_q <= 1'b1;
    end else if (data_gnt_i) begin
      req_q <= 1'b0;
    end
  end

  // Held stable until granted
  always_ff @(posedge clk_i) begin
    if (store_i.valid) begin
      addr_q  <= store_i.addr;
      wdata_q <= store_i.wdata;
    end
  end

  // Free again in the grant cycle
  assign busy_o = req_q & ~data_gnt_i;

  assign data_req_o   = req_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

endmodule

/* hw/mini_rv_core.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module mini_rv_core
  import core_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [`XLEN-1:0] boot_addr_i,
  // Instruction fetch port
  output logic             instr_req_o,
  input  logic             instr_gnt_i,
  output logic [`XLEN-1:0] instr_addr_o,
  input  logic             instr_rvalid_i,
  input  logic [`XLEN-1:0] instr_rdata_i,
  // Data store port
  output logic             data_req_o,
  input  logic             data_gnt_i,
  output logic [`XLEN-1:0] data_addr_o,
  output logic [`XLEN-1:0] data_wdata_o
);

  // IF to ID
  fetch_t                 fetch;
  logic                   fetch_valid;
  logic                   fetch_ready;
  // Register file reads
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;
  // ID to EX and back
  id_ex_t                 id_ex;
  logic                   ex_ready;
  logic                   rf_we;
  logic [`REG_ADDR_W-1:0] rf_waddr;
  logic [`XLEN-1:0]       rf_wdata;
  // EX to LSU
  store_req_t             store_req;
  logic                   lsu_busy;

  //////////////////////////////////////////////////
  // Fetch and decode
  //////////////////////////////////////////////////

  if_stage u_if_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .fetch_o        (fetch),
    .fetch_valid_o  (fetch_valid),
    .fetch_ready_i  (fetch_ready)
  );

  id_stage u_id_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_i       (fetch),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    // Execute result doubles as bypass
    .fwd_we_i      (rf_we),
    .fwd_addr_i    (rf_waddr),
    .fwd_data_i    (rf_wdata),
    .ex_ready_i    (ex_ready),
    .id_ex_o       (id_ex)
  );

  regfile u_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .we_i      (rf_we),
    .waddr_i   (rf_waddr),
    .wdata_i   (rf_wdata)
  );

  //////////////////////////////////////////////////
  // Execute and store path
  //////////////////////////////////////////////////

  ex_stage u_ex_stage (
    .id_ex_i    (id_ex),
    .lsu_busy_i (lsu_busy),
    .ex_ready_o (ex_ready),
    .rf_we_o    (rf_we),
    .rf_waddr_o (rf_waddr),
    .rf_wdata_o (rf_wdata),
    .store_o    (store_req)
  );

  lsu u_lsu (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .store_i      (store_req),
    .busy_o       (lsu_busy),
    .data_req_o   (data_req_o),
    .data_gnt_i   (data_gnt_i),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o)
  );

endmodule

/* hw/regfile.sv */
`timescale 1ns/1ps
`include "core_macros.svh"

module regfile (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`REG_ADDR_W-1:0] raddr_b_i,
  output logic [`XLEN-1:0]       rdata_a_o,
  output logic [`XLEN-1:0]       rdata_b_o,
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i
);

  // x1..x31 only, x0 is hardwired
  logic [`XLEN-1:0] regs_q [1:`NREG-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `NREG; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Asynchronous reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* mini_rv_core.f */
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
hw/if_stage.sv
hw/id_stage.sv
hw/regfile.sv
hw/ex_stage.sv
hw/lsu.sv
hw/mini_rv_core.sv
dv/mini_rv_core_chk.sv
dv/tb_mini_rv_core.sv
